//--- dv/capture_checker.sv
// Assertions on the AXI-L slave of the packet capture subsystem
// Bound into axil_capture_regs from the testbench
`timescale 1ns/1ps

module capture_checker import capture_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  en,
    input logic  arm,
    input logic  bvalid,
    input logic  bready,
    input logic  rvalid,
    input logic  rready,
    input data_t rdata
);

    // Outputs quiet while reset is held
    assert property (@(posedge clk) !rst_n |-> !en && !rvalid)
        else $error("en or rvalid high during reset");

    // Read response held with stable data
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped or rdata changed before rready");

    // Write response held until taken
    assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Arm lasts one cycle
    assert property (@(posedge clk) disable iff (!rst_n) arm |=> !arm)
        else $error("arm pulse longer than one cycle");

endmodule

//--- dv/tb_axis_packet_capture.sv
// Directed testbench for the AXI-S packet capture subsystem
// Sends packets on AXI-S, arms and reads back over AXI-L, compares with a byte model
`timescale 1ns/1ps

module tb_axis_packet_capture import capture_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int DONE_POLLS = 20;

    logic clk;
    logic rst_n;
    logic axis_tvalid;
    logic axis_tready;
    axis_beat_t axis_beat;
    logic awvalid;
    logic awready;
    axil_addr_t awaddr;
    logic wvalid;
    logic wready;
    data_t wdata;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    axil_addr_t araddr;
    logic rvalid;
    logic rready;
    data_t rdata;
    logic en;

    int error_count = 0;
    int timeout_count = 0;

    // Reference model of the current packet
    logic [7:0] pkt_bytes [$];
    meta_t pkt_meta;

    axis_packet_capture dut_i (.*);

    bind axil_capture_regs capture_checker checker_i (
        .clk(clk), .rst_n(rst_n), .en(en), .arm(arm), .bvalid(bvalid), .bready(bready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata)
    );

    always #50 clk = ~clk;

    task automatic expect_equal(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input data_t data);
        int cnt;
        logic taken;
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        // Address and data are taken together at a rising edge
        taken = 1'b0;
        cnt = 0;
        while (!taken && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            taken = awready && wready;
            cnt++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        if (!taken) begin
            timeout_count++;
            $display("Timeout: write address and data never accepted for address %h", addr);
            return;
        end
        cnt = 0;
        while (!bvalid && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        if (!bvalid) begin
            timeout_count++;
            $display("Timeout: no write response for address %h", addr);
            return;
        end
        bready = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (bvalid && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        bready = 1'b0;
        if (bvalid) begin
            timeout_count++;
            $display("Timeout: write response for address %h never cleared", addr);
        end
    endtask

    // hold is the number of cycles rready stays low once rvalid is up
    task automatic axil_read(input axil_addr_t addr, input int hold, output data_t data);
        int cnt;
        logic taken;
        data = '0;
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        taken = 1'b0;
        cnt = 0;
        while (!taken && cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            taken = arready;
            cnt++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (!taken) begin
            timeout_count++;
            $display("Timeout: read address %h never accepted", addr);
            return;
        end
        cnt = 0;
        while (!rvalid && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        if (!rvalid) begin
            timeout_count++;
            $display("Timeout: no read response for address %h", addr);
            return;
        end
        data = rdata;
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid) begin
                error_count++;
                $display("Fail at %0t ns: rvalid dropped while rready was low", $time);
            end
            expect_equal("held read data", rdata, data);
        end
        rready = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (rvalid && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        rready = 1'b0;
        if (rvalid) begin
            timeout_count++;
            $display("Timeout: read response for address %h never cleared", addr);
        end
    endtask

    task automatic wait_done();
        data_t st;
        int polls;
        st = '0;
        polls = 0;
        while (!st[0] && polls < DONE_POLLS) begin
            axil_read(REG_STATUS, 0, st);
            polls++;
        end
        if (!st[0]) begin
            timeout_count++;
            $display("Timeout: capture never reported done");
        end
    endtask

    task automatic make_packet(input int nbytes);
        pkt_bytes.delete();
        for (int i = 0; i < nbytes; i++) begin
            pkt_bytes.push_back(8'($urandom));
        end
        pkt_meta = meta_t'(16'($urandom));
    endtask

    task automatic axis_send_packet();
        int nbeats;
        axis_beat_t b;
        nbeats = (pkt_bytes.size() + 3) / 4;
        for (int i = 0; i < nbeats; i++) begin
            @(negedge clk);
            b = '0;
            b.meta = pkt_meta;
            b.tlast = (i == nbeats - 1);
            for (int k = 0; k < 4; k++) begin
                if (4 * i + k < pkt_bytes.size()) begin
                    b.tkeep[k] = 1'b1;
                    b.tdata[8*k +: 8] = pkt_bytes[4*i+k];
                end else begin
                    // Unkept lanes carry junk that must read back as zero
                    b.tdata[8*k +: 8] = 8'($urandom);
                end
            end
            axis_beat = b;
            axis_tvalid = 1'b1;
        end
        @(negedge clk);
        axis_tvalid = 1'b0;
    endtask

    // First byte of each group of four in the top bits
    function automatic data_t expected_word(input int n);
        data_t w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            if (4 * n + k < pkt_bytes.size()) begin
                w[31-8*k -: 8] = pkt_bytes[4*n+k];
            end
        end
        return w;
    endfunction

    task automatic check_capture(input logic trunc);
        data_t got;
        int nwords;
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS", got, {29'b0, 1'b0, trunc, 1'b1});
        axil_read(REG_LENGTH, 0, got);
        expect_equal("LENGTH", got, 32'(pkt_bytes.size()));
        axil_read(REG_META, 0, got);
        expect_equal("META", got, {16'h0, pkt_meta.tuser, pkt_meta.tdest, pkt_meta.tid});
        nwords = (pkt_bytes.size() + 3) / 4;
        if (nwords > MEM_DEPTH) begin
            nwords = MEM_DEPTH;
        end
        for (int n = 0; n < nwords; n++) begin
            axil_read(MEM_BASE + 16'(4 * n), 0, got);
            expect_equal($sformatf("memory word %0d", n), got, expected_word(n));
        end
    endtask

    task automatic idle_after_reset();
        data_t got;
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS after reset", got, '0);
        expect_equal("en after reset", {31'b0, en}, '0);
        expect_equal("tready after reset", {31'b0, axis_tready}, 32'h1);
        // Nothing is captured while not armed
        make_packet(12);
        axis_send_packet();
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS unarmed", got, '0);
    endtask

    task automatic single_capture();
        data_t got;
        make_packet(1 + int'($urandom % 40));
        axil_write(REG_CONTROL, 32'h1);
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS armed", got, 32'h4);
        expect_equal("en while armed", {31'b0, en}, 32'h1);
        axis_send_packet();
        wait_done();
        expect_equal("en after done", {31'b0, en}, '0);
        check_capture(1'b0);
    endtask

    task automatic arm_mid_packet();
        data_t got;
        make_packet(80);
        fork
            axis_send_packet();
            begin
                repeat (4) @(negedge clk);
                axil_write(REG_CONTROL, 32'h1);
            end
        join
        // Engine still waits since the tail had no start of packet
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS after tail", got, 32'h4);
        make_packet(1 + int'($urandom % 40));
        axis_send_packet();
        wait_done();
        check_capture(1'b0);
    endtask

    task automatic truncated_capture();
        axil_write(REG_CONTROL, 32'h1);
        make_packet(1100);
        axis_send_packet();
        wait_done();
        check_capture(1'b1);
    endtask

    task automatic rearm_and_unmapped();
        data_t got;
        axil_write(REG_CONTROL, 32'h1);
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS after rearm", got, 32'h4);
        make_packet(1 + int'($urandom % 40));
        axis_send_packet();
        wait_done();
        check_capture(1'b0);
        axil_write(16'h0020, 32'hdead_beef);
        axil_read(16'h0020, 0, got);
        expect_equal("unmapped 0x0020", got, '0);
        axil_read(16'h2000, 0, got);
        expect_equal("unmapped 0x2000", got, '0);
        axil_read(REG_STATUS, 0, got);
        expect_equal("STATUS after unmapped write", got, 32'h1);
    endtask

    task automatic read_backpressure();
        data_t got;
        axil_read(REG_LENGTH, 3, got);
        expect_equal("LENGTH with rready low", got, 32'(pkt_bytes.size()));
        axil_read(MEM_BASE, 5, got);
        expect_equal("memory word 0 with rready low", got, expected_word(0));
        axil_read(REG_META, 2, got);
        expect_equal("META with rready low", got,
                     {16'h0, pkt_meta.tuser, pkt_meta.tdest, pkt_meta.tid});
    endtask

    initial begin
        void'($urandom(96022));
        clk = 1'b0;
        rst_n = 1'b0;
        axis_tvalid = 1'b0;
        axis_beat = '0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_equal("tready in reset", {31'b0, axis_tready}, '0);
        rst_n = 1'b1;

        idle_after_reset();
        single_capture();
        arm_mid_packet();
        truncated_capture();
        rearm_and_unmapped();
        read_backpressure();

        $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/capture_pkg.sv
rtl/axis_to_packet.sv
rtl/packet_capture_ctrl.sv
rtl/packet_mem.sv
rtl/axil_capture_regs.sv
rtl/axis_packet_capture.sv
dv/capture_checker.sv
dv/tb_axis_packet_capture.sv

//--- rtl/axil_capture_regs.sv
// AXI4-Lite slave for the packet capture control plane
// Control, status, length and meta registers plus readback of the packet memory
// Reads take two cycles so memory data can be selected after its read latency
`timescale 1ns/1ps

module axil_capture_regs import capture_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    // Write address and data
    input  logic            awvalid,
    output logic            awready,
    input  axil_addr_t      awaddr,
    input  logic            wvalid,
    output logic            wready,
    input  data_t           wdata,
    // Write response
    output logic            bvalid,
    input  logic            bready,
    // Read address
    input  logic            arvalid,
    output logic            arready,
    input  axil_addr_t      araddr,
    // Read data
    output logic            rvalid,
    input  logic            rready,
    output data_t           rdata,
    // Capture engine side
    input  capture_status_t status,
    input  logic            en,
    output logic            arm,
    output mem_addr_t       rd_addr,
    input  data_t           rd_data
);

    logic  wr_fire;
    logic  ar_fire;
    logic  s1_valid;
    logic  s1_is_mem;
    data_t s1_reg_data;
    data_t reg_rdata;
    logic  ar_is_mem;

    // Address and data accepted together, never while a response is pending
    assign awready = awvalid && wvalid && !bvalid;
    assign wready = awvalid && wvalid && !bvalid;
    assign wr_fire = awvalid && wvalid && !bvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            arm <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // Self-clearing arm bit, other addresses are silently ignored
            arm <= wr_fire && (awaddr == REG_CONTROL) && wdata[0];
        end
    end

    // One read in flight at a time
    assign arready = !s1_valid && !rvalid;
    assign ar_fire = arvalid && arready;

    // Memory is addressed straight from araddr, data comes back next cycle
    assign rd_addr = araddr[MEM_ADDR_W+1:2];
    assign ar_is_mem = (araddr >= MEM_BASE) &&
                       (int'(araddr) < int'(MEM_BASE) + MEM_DEPTH * DATA_BYTES);

    always_comb begin
        reg_rdata = '0;
        case (araddr)
            // Bit 2 reports armed
            REG_STATUS: reg_rdata = {29'b0, en, status.truncated, status.done};
            REG_LENGTH: reg_rdata = {16'h0000, status.length};
            REG_META: reg_rdata = {16'h0000, status.meta};
            // Control and unmapped addresses read as zero
            default: reg_rdata = '0;
        endcase
    end

    // Read pipeline control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            s1_valid <= ar_fire;
            if (s1_valid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read pipeline data
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            s1_is_mem <= ar_is_mem;
            s1_reg_data <= reg_rdata;
        end
        // rdata only loads when a new read completes, so it holds until rready
        if (s1_valid) begin
            rdata <= s1_is_mem ? rd_data : s1_reg_data;
        end
    end

endmodule

//--- rtl/axis_packet_capture.sv
// Top level of the AXI-S packet capture subsystem
// Stream in from the data plane, AXI4-Lite out to the control plane
`timescale 1ns/1ps

module axis_packet_capture import capture_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // AXI-S sink
    input  logic       axis_tvalid,
    output logic       axis_tready,
    input  axis_beat_t axis_beat,
    // AXI-L slave
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  data_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output data_t      rdata,
    // High while capture is armed
    output logic       en
);

    logic            word_valid;
    packet_word_t    word;
    mem_wr_t         mem_wr;
    capture_status_t status;
    logic            arm;
    mem_addr_t       rd_addr;
    data_t           rd_data;

    // Sink never stalls once out of reset
    assign axis_tready = rst_n;

    axis_to_packet adapter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .axis_tvalid (axis_tvalid),
        .beat        (axis_beat),
        .word_valid  (word_valid),
        .word        (word)
    );

    packet_capture_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .arm        (arm),
        .word_valid (word_valid),
        .word       (word),
        .mem_wr     (mem_wr),
        .status     (status),
        .en         (en)
    );

    packet_mem mem_i (
        .clk     (clk),
        .wr      (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axil_capture_regs regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .status  (status),
        .en      (en),
        .arm     (arm),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- rtl/axis_to_packet.sv
// Adapter from AXI-S beats to packet words for the capture engine
// Marks start of packet, counts kept bytes and reorders bytes for the memory
`timescale 1ns/1ps

module axis_to_packet import capture_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         axis_tvalid,
    input  axis_beat_t   beat,
    output logic         word_valid,
    output packet_word_t word
);

    // High when the next beat opens a packet
    logic sop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop <= 1'b1;
        end else if (axis_tvalid) begin
            // A tlast beat means the following beat is a new packet
            sop <= beat.tlast;
        end
    end

    // Stream never stalls, so every valid beat is a word
    assign word_valid = axis_tvalid;

    always_comb begin
        word = '0;
        word.sop = sop;
        word.eop = beat.tlast;
        word.meta = beat.meta;
        // tkeep is contiguous from byte 0, so counting set bits gives the length
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (beat.tkeep[i]) begin
                word.nbytes = word.nbytes + 1'b1;
                if (NETWORK_BYTE_ORDER) begin
                    word.data[8*(DATA_BYTES-1-i) +: 8] = beat.tdata[8*i +: 8];
                end else begin
                    word.data[8*i +: 8] = beat.tdata[8*i +: 8];
                end
            end
            // Unkept bytes stay zero from the default above
        end
    end

endmodule

//--- rtl/capture_pkg.sv
// Shared widths, types and register map for the AXI-S packet capture subsystem
// Imported by every RTL module and by the testbench
package capture_pkg;

    // Data plane geometry
    localparam int DATA_BYTES = 4;
    localparam int MEM_DEPTH = 256;
    localparam int MEM_ADDR_W = 8;
    // Byte 0 of tdata lands in the top byte of a memory word when set
    localparam bit NETWORK_BYTE_ORDER = 1'b1;
    localparam int AXIL_ADDR_W = 16;

    typedef logic [8*DATA_BYTES-1:0] data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;
    typedef logic [3:0] tid_t;
    typedef logic [3:0] tdest_t;
    typedef logic [7:0] tuser_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    // Packet length in bytes
    typedef logic [15:0] byte_len_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;

    // Field order matches the META register layout, tuser on top
    typedef struct packed {
        tuser_t tuser;
        tdest_t tdest;
        tid_t   tid;
    } meta_t;

    typedef struct packed {
        data_t tdata;
        keep_t tkeep;
        logic  tlast;
        meta_t meta;
    } axis_beat_t;

    typedef struct packed {
        data_t                       data;
        logic                        sop;
        logic                        eop;
        // Valid bytes in this word, 1 to DATA_BYTES
        logic [$clog2(DATA_BYTES):0] nbytes;
        meta_t                       meta;
    } packet_word_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        data_t     data;
    } mem_wr_t;

    typedef struct packed {
        logic      done;
        logic      truncated;
        byte_len_t length;
        meta_t     meta;
    } capture_status_t;

    // Register map
    localparam axil_addr_t REG_CONTROL = 16'h0000;
    localparam axil_addr_t REG_STATUS = 16'h0004;
    localparam axil_addr_t REG_LENGTH = 16'h0008;
    localparam axil_addr_t REG_META = 16'h000C;
    localparam axil_addr_t MEM_BASE = 16'h1000;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SOP,
        CAPTURE,
        DONE
    } capture_state_e;

endpackage

//--- rtl/packet_capture_ctrl.sv
// Capture engine FSM for one packet per arm request
// Writes packet words to memory at line rate and keeps length, meta and truncation
// Status fields are read by the register slave
`timescale 1ns/1ps

module packet_capture_ctrl import capture_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            arm,
    input  logic            word_valid,
    input  packet_word_t    word,
    output mem_wr_t         mem_wr,
    output capture_status_t status,
    output logic            en
);

    capture_state_e state;

    // Words stored so far, one extra bit so a full memory is visible
    logic [MEM_ADDR_W:0] word_cnt;

    logic accept;
    logic start;
    logic room;

    // Packet start restarts at address 0
    assign start = word.sop;

    // WAIT_SOP only takes a packet start, CAPTURE takes everything
    assign accept = word_valid &&
                    (((state == WAIT_SOP) && word.sop) || (state == CAPTURE));

    // Space left for a continuation word
    assign room = start || (word_cnt < MEM_DEPTH);

    assign en = (state == WAIT_SOP) || (state == CAPTURE);

    // Memory write happens in the same cycle the word arrives
    always_comb begin
        mem_wr.en = accept && room;
        mem_wr.addr = start ? '0 : word_cnt[MEM_ADDR_W-1:0];
        mem_wr.data = word.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            word_cnt <= '0;
            status <= '0;
        end else begin
            // Arm only from idle or after a finished capture
            if (arm && ((state == IDLE) || (state == DONE))) begin
                state <= WAIT_SOP;
                status.done <= 1'b0;
                status.truncated <= 1'b0;
            end

            if (accept) begin
                if (start) begin
                    word_cnt <= 1;
                    status.length <= byte_len_t'(word.nbytes);
                    // Meta is taken from the first word only
                    status.meta <= word.meta;
                    status.truncated <= 1'b0;
                end else begin
                    if (room) begin
                        word_cnt <= word_cnt + 1'b1;
                    end else begin
                        // Word dropped, length still counts it
                        status.truncated <= 1'b1;
                    end
                    status.length <= status.length + byte_len_t'(word.nbytes);
                end

                if (word.eop) begin
                    state <= DONE;
                    status.done <= 1'b1;
                end else begin
                    state <= CAPTURE;
                end
            end
        end
    end

endmodule

//--- rtl/packet_mem.sv
// Word memory holding the captured packet
// One write port from the capture engine, one registered read port for readback
`timescale 1ns/1ps

module packet_mem import capture_pkg::*; (
    input  logic      clk,
    input  mem_wr_t   wr,
    input  mem_addr_t rd_addr,
    output data_t     rd_data
);

    // Inferred block RAM
    data_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        // Read data one cycle after the address
        rd_data <= mem[rd_addr];
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the packet capture testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_axis_packet_capture \
    -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
